// ==== design/scanTypesPkg.sv ====
package scanTypesPkg;

	// Scanner FSM states
	typedef enum logic [1:0] {
		idle     = 2'b00,
		active   = 2'b01,
		standby  = 2'b10,
		transfer = 2'b11
	} scanState_t;

	// Command level driven by the peer scanner
	typedef enum logic [1:0] {
		none      = 2'b00,
		startScan = 2'b01,
		peerHalf  = 2'b10
	} localCommand_t;

	localparam int fillWidth = 4;

	// Fill levels that trigger a command frame
	localparam logic [fillWidth-1:0] fillReadyLevel = 4'd7; // About 80 percent
	localparam logic [fillWidth-1:0] fillStartLevel = 4'd8; // About 90 percent
	localparam logic [fillWidth-1:0] fillFullLevel  = 4'd9; // Buffer full

endpackage

// ==== design/linkProtocolPkg.sv ====
package linkProtocolPkg;

	// Bits per serial frame, sent MSB first
	localparam int frameWidth = 8;

	// Width of the bit counter inside the transmitter
	localparam int bitCountWidth = $clog2(frameWidth);

	// Command frames understood by the output driver
	typedef enum logic [frameWidth-1:0] {
		opReadyToTransfer = 8'd2,
		opStartScanning   = 8'd3,
		opBufferFull      = 8'd4,
		opDataTransfer    = 8'd7
	} linkOpcode_t;

	// The data frame that follows opDataTransfer has no opcode of its own.
	// It carries the fill count, zero-extended to frameWidth bits.

endpackage

// ==== design/tickDivider.sv ====
`timescale 1ns/1ps

module tickDivider #(
	parameter int tickDivide = 16
) (
	input  logic clk,
	input  logic rst,
	output logic scanTick
);

	localparam int countWidth = $clog2(tickDivide);
	localparam logic [countWidth-1:0] lastCount = countWidth'(tickDivide - 1);

	logic [countWidth-1:0] count;

	// Slow buffer timebase as a one-cycle enable on the fast clock
	always_ff @(posedge clk) begin
		if (rst) begin
			count    <= '0;
			scanTick <= 1'b0;
		end else if (count == lastCount) begin
			count    <= '0;
			scanTick <= 1'b1; // One tick per wrap
		end else begin
			count    <= count + 1'b1;
			scanTick <= 1'b0;
		end
	end

endmodule

// ==== design/scanController.sv ====
`timescale 1ns/1ps

module scanController
	import scanTypesPkg::*;
	import linkProtocolPkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  scanTick,
	input  logic                  readyForTransfer,
	input  localCommand_t         localCommand,
	input  logic                  txReady,
	output logic                  frameLoad,
	output logic [frameWidth-1:0] frameByte,
	output scanState_t            scanState
);

	logic [fillWidth-1:0]  fill;
	logic [fillWidth-1:0]  nextFill;
	logic                  pendingValid; // A frame waits for the transmitter
	logic [frameWidth-1:0] pendingByte;
	logic                  cmdSent;      // opDataTransfer already handed over
	logic                  levelHit;
	linkOpcode_t           levelOp;
	logic [frameWidth-1:0] dataByte;

	assign nextFill  = fill + 1'b1;
	assign dataByte  = {{(frameWidth - fillWidth){1'b0}}, fill}; // Fill count as payload
	assign frameLoad = pendingValid && txReady; // Only handed over when ready
	assign frameByte = pendingByte;

	// Opcode announced when the fill reaches one of the thresholds
	always_comb begin
		levelHit = 1'b1;
		levelOp  = opReadyToTransfer;
		case (nextFill)
			fillReadyLevel: levelOp = opReadyToTransfer;
			fillStartLevel: levelOp = opStartScanning;
			fillFullLevel:  levelOp = opBufferFull;
			default:        levelHit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			scanState    <= idle;
			fill         <= '0;
			pendingValid <= 1'b0;
			cmdSent      <= 1'b0;
		end else begin
			// Default hand-over that transfer may requeue below
			if (frameLoad)
				pendingValid <= 1'b0;

			case (scanState)
				idle: begin
					if (localCommand == startScan)
						scanState <= active;
				end

				active: begin
					if (fill == fillFullLevel) begin
						// Decide only after opBufferFull has left
						if (!pendingValid)
							scanState <= readyForTransfer ? transfer : standby;
					end else if (scanTick && !pendingValid) begin
						fill <= nextFill; // Stand-in for a new sample
						if (levelHit) begin
							pendingValid <= 1'b1;
							pendingByte  <= levelOp;
						end
					end
				end

				standby: begin
					if (localCommand == peerHalf) begin
						// Peer buffer half full so our data is dropped
						scanState <= idle;
						fill      <= '0;
					end else if (readyForTransfer) begin
						scanState <= transfer;
					end
				end

				transfer: begin
					if (!pendingValid && !cmdSent) begin
						pendingValid <= 1'b1;
						pendingByte  <= opDataTransfer;
					end else if (frameLoad && !cmdSent) begin
						// Data frame follows the command
						cmdSent      <= 1'b1;
						pendingValid <= 1'b1;
						pendingByte  <= dataByte;
					end else if (frameLoad) begin
						// Buffer empty once the data frame is loaded
						cmdSent   <= 1'b0;
						fill      <= '0;
						scanState <= idle;
					end
				end

				default: begin
					scanState <= idle;
				end
			endcase
		end
	end

endmodule

// ==== design/serialTransmitter.sv ====
`timescale 1ns/1ps

module serialTransmitter
	import linkProtocolPkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frameLoad,
	input  logic [frameWidth-1:0] frameByte,
	output logic                  txReady,
	output logic                  serialData,
	output logic                  serialValid
);

	localparam logic [bitCountWidth-1:0] lastBit = bitCountWidth'(frameWidth - 1);

	logic [frameWidth-1:0]    shiftReg;
	logic [bitCountWidth-1:0] bitCount; // Bits still to send after this one
	logic                     busy;

	assign txReady     = !busy;
	assign serialValid = busy; // Stands in for the gated bit clock
	assign serialData  = busy && shiftReg[frameWidth-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			bitCount <= '0;
		end else if (!busy) begin
			if (frameLoad) begin
				busy     <= 1'b1;
				bitCount <= lastBit;
			end
		end else begin
			bitCount <= bitCount - 1'b1;
			if (bitCount == '0)
				busy <= 1'b0; // Ready again after the last bit
		end
	end

	// Frame shifts out MSB first
	always_ff @(posedge clk) begin
		if (frameLoad && !busy)
			shiftReg <= frameByte;
		else if (busy)
			shiftReg <= {shiftReg[frameWidth-2:0], 1'b0};
	end

endmodule

// ==== design/scanSubsystem.sv ====
`timescale 1ns/1ps

module scanSubsystem
	import scanTypesPkg::*;
	import linkProtocolPkg::*;
#(
	parameter int tickDivide = 16
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          readyForTransfer,
	input  localCommand_t localCommand,
	output logic          serialData,
	output logic          serialValid,
	output scanState_t    scanState
);

	logic                  scanTick;
	logic                  frameLoad;
	logic [frameWidth-1:0] frameByte;
	logic                  txReady;

	// Slow scan rate
	tickDivider #(
		.tickDivide(tickDivide)
	) divider (
		.clk     (clk),
		.rst     (rst),
		.scanTick(scanTick)
	);

	scanController controller (
		.clk             (clk),
		.rst             (rst),
		.scanTick        (scanTick),
		.readyForTransfer(readyForTransfer),
		.localCommand    (localCommand),
		.txReady         (txReady),
		.frameLoad       (frameLoad),
		.frameByte       (frameByte),
		.scanState       (scanState)
	);

	// Serial link to the output driver
	serialTransmitter transmitter (
		.clk        (clk),
		.rst        (rst),
		.frameLoad  (frameLoad),
		.frameByte  (frameByte),
		.txReady    (txReady),
		.serialData (serialData),
		.serialValid(serialValid)
	);

endmodule

// ==== testbench/serialFrameCollector.sv ====
`timescale 1ns/1ps

module serialFrameCollector
	import linkProtocolPkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  serialData,
	input  logic                  serialValid,
	output logic                  frameDone,
	output logic [frameWidth-1:0] frameByte,
	output logic [7:0]            runLength
);

	logic [frameWidth-1:0] shiftIn;
	logic [7:0]            validCount; // Valid cycles in the current run

	always_ff @(posedge clk) begin
		if (rst) begin
			shiftIn    <= '0;
			validCount <= '0;
			frameDone  <= 1'b0;
			frameByte  <= '0;
			runLength  <= '0;
		end else begin
			frameDone <= 1'b0;
			if (serialValid) begin
				shiftIn    <= {shiftIn[frameWidth-2:0], serialData}; // MSB arrives first
				validCount <= validCount + 1'b1;
			end else if (validCount != '0) begin
				// Byte and length held until the next frame ends
				frameDone  <= 1'b1;
				frameByte  <= shiftIn;
				runLength  <= validCount;
				validCount <= '0;
			end
		end
	end

endmodule

// ==== testbench/scanSubsystemTb.sv ====
`timescale 1ns/1ps

module scanSubsystemTb
	import scanTypesPkg::*;
	import linkProtocolPkg::*;
();

	localparam int tickDivide     = 4;
	localparam int scenarioCycles = 2000; // Generous bound for all four scans
	localparam int watchdogCycles = 2 * scenarioCycles;
	localparam logic [7:0] frameReady = 8'h02;
	localparam logic [7:0] frameStart = 8'h03;
	localparam logic [7:0] frameFull  = 8'h04;
	localparam logic [7:0] frameXfer  = 8'h07;
	localparam logic [7:0] frameData  = 8'h09; // Fill count at full

	logic          clk;
	logic          rst;
	logic          readyForTransfer;
	localCommand_t localCommand;
	logic          serialData;
	logic          serialValid;
	scanState_t    scanState;

	logic                  frameDone;
	logic [frameWidth-1:0] frameByte;
	logic [7:0]            runLength;
	logic [7:0]            expectFrames [0:31];
	logic [7:0]            expectedByte;
	int                    expectCount;
	int                    frameIndex;
	logic [31:0]           lcgState;
	logic                  resetSeen;
	logic                  scanStarted;
	logic                  expectStandby; // Link must stay quiet in standby
	logic                  expectIdle;    // Quiet idle after peerHalf

	scanSubsystem #(.tickDivide(tickDivide)) uut (
		.clk             (clk),
		.rst             (rst),
		.readyForTransfer(readyForTransfer),
		.localCommand    (localCommand),
		.serialData      (serialData),
		.serialValid     (serialValid),
		.scanState       (scanState)
	);

	serialFrameCollector collector (
		.clk        (clk),
		.rst        (rst),
		.serialData (serialData),
		.serialValid(serialValid),
		.frameDone  (frameDone),
		.frameByte  (frameByte),
		.runLength  (runLength)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign expectedByte = (frameIndex < 32) ? expectFrames[frameIndex] : 8'h00;

	always @(posedge clk) begin
		if (rst) begin
			resetSeen  <= 1'b1;
			frameIndex <= 0;
		end else if (frameDone) begin
			frameIndex <= frameIndex + 1;
		end
	end

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "Simulation stopped");
	endtask

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic randomIdle();
		lcgState = lcgStep(lcgState);
		repeat (1 + lcgState[18:16]) @(posedge clk);
		#2;
	endtask

	task automatic addFrame(input logic [7:0] value);
		expectFrames[expectCount] = value;
		expectCount = expectCount + 1;
	endtask

	// One scan up to full plus the hand-over when ready
	task automatic expectScan(input logic ready);
		addFrame(frameReady);
		addFrame(frameStart);
		addFrame(frameFull);
		if (ready) begin
			addFrame(frameXfer);
			addFrame(frameData);
		end
	endtask

	task automatic issueCommand(input localCommand_t cmd);
		randomIdle();
		localCommand = cmd;
		if (cmd == startScan)
			scanStarted = 1'b1;
		@(posedge clk);
		#2;
		localCommand = none;
	endtask

	task automatic waitFrames();
		while (frameIndex != expectCount) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic waitStandby();
		waitFrames();
		while (scanState != standby) begin
			@(posedge clk);
			#2;
		end
		expectStandby = 1'b1;
		repeat (3 * tickDivide) @(posedge clk); // Several ticks with no frame
		#2;
	endtask

	quietBeforeStart: assert property (@(posedge clk) resetSeen && !scanStarted |-> !serialValid)
		else stopOnFailure($sformatf("CHECK FAILED serialValid got %h expected %h",
			$sampled(serialValid), 1'b0));
	idleBeforeStart: assert property (@(posedge clk)
		resetSeen && !scanStarted |-> scanState == idle)
		else stopOnFailure($sformatf("CHECK FAILED scanState got %h expected %h",
			$sampled(scanState), idle));
	frameLength: assert property (@(posedge clk) disable iff (rst) frameDone |-> runLength == 8)
		else stopOnFailure($sformatf("CHECK FAILED runLength got %h expected %h",
			$sampled(runLength), 8'h08));
	frameWanted: assert property (@(posedge clk) disable iff (rst)
		frameDone |-> frameIndex < expectCount)
		else stopOnFailure($sformatf("Frame %h arrived when no frame was expected",
			$sampled(frameByte)));
	frameOrder: assert property (@(posedge clk) disable iff (rst)
		frameDone && frameIndex < expectCount |-> frameByte == expectedByte)
		else stopOnFailure($sformatf("CHECK FAILED frameByte got %h expected %h",
			$sampled(frameByte), $sampled(expectedByte)));
	idleAfterData: assert property (@(posedge clk) disable iff (rst)
		frameDone && frameByte == frameData |-> scanState == idle)
		else stopOnFailure($sformatf("CHECK FAILED scanState got %h expected %h",
			$sampled(scanState), idle));
	standbyHeld: assert property (@(posedge clk) expectStandby |-> scanState == standby)
		else stopOnFailure($sformatf("CHECK FAILED scanState got %h expected %h",
			$sampled(scanState), standby));
	standbyQuiet: assert property (@(posedge clk) expectStandby |-> !serialValid)
		else stopOnFailure($sformatf("CHECK FAILED serialValid got %h expected %h",
			$sampled(serialValid), 1'b0));
	peerHalfIdle: assert property (@(posedge clk) expectIdle |-> scanState == idle)
		else stopOnFailure($sformatf("CHECK FAILED scanState got %h expected %h",
			$sampled(scanState), idle));
	peerHalfQuiet: assert property (@(posedge clk) expectIdle |-> !serialValid)
		else stopOnFailure($sformatf("CHECK FAILED serialValid got %h expected %h",
			$sampled(serialValid), 1'b0));

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		stopOnFailure("Timeout, the scenarios did not finish in time");
	end

	initial begin
		lcgState         = 32'h81d8_bb42;
		rst              = 1'b1;
		readyForTransfer = 1'b0;
		localCommand     = none;
		resetSeen        = 1'b0;
		scanStarted      = 1'b0;
		expectStandby    = 1'b0;
		expectIdle       = 1'b0;
		expectCount      = 0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		randomIdle();

		// Receiver ready when the buffer fills
		readyForTransfer = 1'b1;
		expectScan(1'b1);
		issueCommand(startScan);
		waitFrames();

		// Receiver busy at full and ready later
		readyForTransfer = 1'b0;
		expectScan(1'b0);
		issueCommand(startScan);
		waitStandby();
		expectStandby = 1'b0;
		addFrame(frameXfer);
		addFrame(frameData);
		readyForTransfer = 1'b1;
		waitFrames();

		// Peer half full while in standby drops the data
		readyForTransfer = 1'b0;
		expectScan(1'b0);
		issueCommand(startScan);
		waitStandby();
		expectStandby = 1'b0;
		issueCommand(peerHalf);
		expectIdle = 1'b1;
		repeat (12 * tickDivide) @(posedge clk);
		#2;
		expectIdle = 1'b0;

		// Fresh scan from an empty fill
		readyForTransfer = 1'b1;
		expectScan(1'b1);
		issueCommand(startScan);
		waitFrames();

		if (scanState == idle) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			stopOnFailure("State did not settle in idle after the last scenario");
		end
	end

endmodule

// ==== scanSubsystem.f ====
design/scanTypesPkg.sv
design/linkProtocolPkg.sv
design/tickDivider.sv
design/scanController.sv
design/serialTransmitter.sv
design/scanSubsystem.sv
testbench/serialFrameCollector.sv
testbench/scanSubsystemTb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = scanSubsystemTb
FILELIST  = scanSubsystem.f
OBJDIR    = obj_dir
LINTFLAGS = --lint-only --timing --assert
SIMFLAGS  = --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails with a non-zero status when the testbench calls $fatal
sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
